/* hdl/scroll_pkg.sv */
// #########################################################
// scroll video package
// raster timing limits, layer count, pixel width and the
// per-layer constant scroll offsets
// #########################################################

`default_nettype none

package scroll_pkg;

    // layers, layer 0 is the front one
    localparam int n_layers = 2;

    // raster geometry in pixels and lines
    localparam logic [8:0] h_total      = 9'd384;  // pixels per line.
    localparam logic [8:0] v_total      = 9'd264;  // lines per frame.
    localparam logic [8:0] h_active_end = 9'd256;  // first blanked column.
    localparam logic [8:0] v_active_end = 9'd224;  // first blanked line.

    // colour index
    localparam int pxl_w = 6;

    // index 3f marks an empty pixel, the mixer looks through it
    localparam logic [pxl_w-1:0] transparent_pxl = 6'h3f;

    // fixed horizontal offset added to each layer's scroll register
    localparam logic [n_layers-1:0][15:0] layer_hoffset = {
        16'd8,  // layer 1.
        16'd0   // layer 0.
    };

endpackage

`default_nettype wire

/* hdl/pal_prom.sv */
// #########################################################
// palette prom, 256 x 4
// written from the loader port, read through a register
// #########################################################

`timescale 1ns/1ps
`default_nettype none

module pal_prom (
    input  logic       clk,
    input  logic       we,
    input  logic [7:0] wr_addr,
    input  logic [7:0] rd_addr,
    input  logic [3:0] data,
    output logic [3:0] q
);

    logic [3:0] mem [256];  // colour nibbles.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;  // loader write.
        end
        q <= mem[rd_addr];  // one clk read latency.
    end

endmodule

`default_nettype wire

/* hdl/video_timing.sv */
// #########################################################
// raster timing generator
// pixel enable at clk/2, h/v counters, blanking levels and
// the flip-adjusted screen column used by the layers
// #########################################################

`timescale 1ns/1ps
`default_nettype none

module video_timing import scroll_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flip,
    output logic       pxl_cen,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic [9:0] hf,
    output logic       hblank,
    output logic       vblank
);

    logic [9:0] hfix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            h       <= '0;
            v       <= '0;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                if (h == h_total - 9'd1) begin
                    h <= '0;
                    v <= (v == v_total - 9'd1) ? 9'd0 : v + 9'd1;  // next line.
                end else begin
                    h <= h + 9'd1;
                end
            end
        end
    end

    assign hblank = h >= h_active_end;
    assign vblank = v >= v_active_end;

    // three column regions; the low byte runs backwards under flip
    always_comb begin
        if (h > 9'h0c0 && h < 9'h100) begin
            hfix = {2'h3 ^ {flip, 1'b0}, h[7:0]};
        end else if (h[8]) begin
            hfix = {2'h0, h[7:0]};  // blanking tail.
        end else begin
            hfix = {2'h1 ^ {flip, 1'b0}, h[7:0]};
        end
        hfix[7:0] = hfix[7:0] ^ {8{flip}};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hf <= '0;
        end else begin
            hf <= hfix;  // lags h by one clk.
        end
    end

endmodule

`default_nettype wire

/* hdl/scroll_layer.sv */
// #########################################################
// tile scroll layer
// fetches map entries and tile rows, shifts out 2-bit pixels
// and maps them through the palette proms
// #########################################################

`timescale 1ns/1ps
`default_nettype none

module scroll_layer import scroll_pkg::*; #(
    parameter logic [15:0] HOFFSET = 16'd0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic [8:0]       h,
    input  logic [8:0]       v,
    input  logic [9:0]       hf,
    input  logic             flip,
    input  logic [2:0]       pal_bank,
    input  logic [15:0]      hpos,
    input  logic             layer_on,    // low gives transparent output.
    // palette loader
    input  logic [7:0]       prog_addr,
    input  logic [3:0]       prog_din,
    input  logic [1:0]       prom_we,
    // map rom
    output logic [11:0]      map_addr,
    output logic             map_cs,
    input  logic [15:0]      map_data,
    input  logic             map_ok,
    // tile rom
    output logic [13:2]      rom_addr,
    input  logic [31:0]      rom_data,
    input  logic             rom_ok,
    output logic [pxl_w-1:0] pxl
);

    logic [15:0] hpos_adj;
    logic [15:0] heff;    // column under the beam.
    logic [15:0] hadv;    // column one tile ahead.
    logic        hflip;
    logic        vflip;
    logic        hflip_q;
    logic [15:0] pxl_msb;
    logic [15:0] pxl_lsb;
    logic [2:0]  pal_hsb;
    logic [1:0]  cur_pxl;
    logic [7:0]  pal_addr;
    logic [3:0]  prom_lo;
    logic [3:0]  prom_hi;

    assign hpos_adj = hpos + HOFFSET;

    // map entry attribute bits, both relative to screen flip
    assign hflip = map_data[6] ^ flip;
    assign vflip = map_data[7] ^ flip;

    always_comb begin
        heff = hpos_adj + {{6{hf[9]}}, hf};
        if (flip) begin
            heff = heff - 16'd11;  // flipped screen alignment.
        end
        hadv = flip ? heff - 16'h10 : heff + 16'h10;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_addr <= '0;
            map_cs   <= 1'b0;
            rom_addr <= '0;
            pxl_msb  <= '0;
            pxl_lsb  <= '0;
            pal_hsb  <= '0;
            hflip_q  <= 1'b0;
        end else if (pxl_cen) begin
            if (heff[3:0] == 4'd0) begin
                // tile boundary: take the fetched row, ask for the next tile
                pxl_msb  <= {rom_data[3:0], rom_data[11:8],
                             rom_data[19:16], rom_data[27:24]};
                pxl_lsb  <= {rom_data[7:4], rom_data[15:12],
                             rom_data[23:20], rom_data[31:28]};
                hflip_q  <= hflip;
                pal_hsb  <= map_data[10:8];
                map_addr <= {hadv[13:8], v[7:5] ^ {3{flip}}, hadv[7:5]};
                map_cs   <= 1'b1;
            end else begin
                if (map_cs && map_ok) begin
                    map_cs   <= 1'b0;
                    rom_addr <= {map_data[5:0], v[4:0] ^ {5{vflip}}, heff[4] ^ ~hflip};
                end
                if (hflip_q) begin
                    pxl_msb <= pxl_msb >> 1;
                    pxl_lsb <= pxl_lsb >> 1;
                end else begin
                    pxl_msb <= pxl_msb << 1;
                    pxl_lsb <= pxl_lsb << 1;
                end
            end
        end
    end

    // pixel leaves from the end the shift direction empties
    assign cur_pxl = hflip_q ? {pxl_msb[0], pxl_lsb[0]} : {pxl_msb[15], pxl_lsb[15]};

    assign pal_addr = {pal_bank, pal_hsb, cur_pxl};

    pal_prom u_prom_lo (
        .clk     (clk),
        .we      (prom_we[0]),
        .wr_addr (prog_addr),
        .rd_addr (pal_addr),
        .data    (prog_din),
        .q       (prom_lo)
    );

    pal_prom u_prom_hi (
        .clk     (clk),
        .we      (prom_we[1]),
        .wr_addr (prog_addr),
        .rd_addr (pal_addr),
        .data    (prog_din),
        .q       (prom_hi)
    );

    assign pxl = layer_on ? {prom_hi[1:0], prom_lo} : transparent_pxl;

endmodule

`default_nettype wire

/* hdl/layer_mixer.sv */
// #########################################################
// layer priority mixer
// front-most opaque layer wins, output blanked and registered
// #########################################################

`timescale 1ns/1ps
`default_nettype none

module layer_mixer import scroll_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             hblank,
    input  logic             vblank,
    input  logic [pxl_w-1:0] layer_pxl [n_layers],
    output logic [pxl_w-1:0] pixel_out
);

    logic [pxl_w-1:0] pick;

    // walk from the back so the lowest opaque index is left standing
    always_comb begin
        pick = transparent_pxl;
        for (int i = n_layers - 1; i >= 0; i--) begin
            if (layer_pxl[i] != transparent_pxl) begin
                pick = layer_pxl[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_out <= '0;
        end else if (hblank || vblank) begin
            pixel_out <= '0;  // black outside the active area.
        end else begin
            pixel_out <= pick;
        end
    end

endmodule

`default_nettype wire

/* hdl/scroll_top.sv */
// #########################################################
// two-layer tile scroll video top
// raster timing, the scroll layers and the priority mixer
// #########################################################

`timescale 1ns/1ps
`default_nettype none

module scroll_top import scroll_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flip,
    // raster
    output logic                         pxl_cen,
    output logic [8:0]                   h,
    output logic [8:0]                   v,
    output logic [9:0]                   hf,
    output logic                         hblank,
    output logic                         vblank,
    // per-layer controls
    input  logic [n_layers-1:0][15:0]    hpos,
    input  logic [n_layers-1:0][2:0]     pal_bank,
    input  logic [n_layers-1:0]          layer_on,
    // palette loader
    input  logic [7:0]                   prog_addr,
    input  logic [3:0]                   prog_din,
    input  logic [2*n_layers-1:0]        prom_we,   // two nibbles per layer.
    // map roms
    output logic [n_layers-1:0][11:0]    map_addr,
    output logic [n_layers-1:0]          map_cs,
    input  logic [n_layers-1:0][15:0]    map_data,
    input  logic [n_layers-1:0]          map_ok,
    // tile roms
    output logic [n_layers-1:0][13:2]    rom_addr,
    input  logic [n_layers-1:0][31:0]    rom_data,
    input  logic [n_layers-1:0]          rom_ok,
    output logic [pxl_w-1:0]             pixel_out
);

    logic [pxl_w-1:0] layer_pxl [n_layers];

    video_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .flip    (flip),
        .pxl_cen (pxl_cen),
        .h       (h),
        .v       (v),
        .hf      (hf),
        .hblank  (hblank),
        .vblank  (vblank)
    );

    for (genvar i = 0; i < n_layers; i++) begin : g_layer
        scroll_layer #(
            .HOFFSET (layer_hoffset[i])
        ) u_layer (
            .clk       (clk),
            .rst       (rst),
            .pxl_cen   (pxl_cen),
            .h         (h),
            .v         (v),
            .hf        (hf),
            .flip      (flip),
            .pal_bank  (pal_bank[i]),
            .hpos      (hpos[i]),
            .layer_on  (layer_on[i]),
            .prog_addr (prog_addr),
            .prog_din  (prog_din),
            .prom_we   (prom_we[2*i +: 2]),
            .map_addr  (map_addr[i]),
            .map_cs    (map_cs[i]),
            .map_data  (map_data[i]),
            .map_ok    (map_ok[i]),
            .rom_addr  (rom_addr[i]),
            .rom_data  (rom_data[i]),
            .rom_ok    (rom_ok[i]),
            .pxl       (layer_pxl[i])
        );
    end

    layer_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .hblank    (hblank),
        .vblank    (vblank),
        .layer_pxl (layer_pxl),
        .pixel_out (pixel_out)
    );

endmodule

`default_nettype wire

/* tests/tb_scroll_top.sv */
// ############################################################
// testbench for the two-layer tile scroll video top
// models the map and tile roms, loads the palette proms and
// checks raster timing, reset, blanking, palette lookup,
// priority and the map and tile row fetches
// ############################################################

`timescale 1ns/1ps
`default_nettype none

module tb_scroll_top import scroll_pkg::*; ();

    localparam int frame_clks   = int'(h_total) * int'(v_total) * 2;
    localparam int timeout_clks = 4 * frame_clks;

    logic                        clk;
    logic                        rst;
    logic                        flip;
    logic                        pxl_cen;
    logic [8:0]                  h;
    logic [8:0]                  v;
    logic [9:0]                  hf;
    logic                        hblank;
    logic                        vblank;
    logic [n_layers-1:0][15:0]   hpos;
    logic [n_layers-1:0][2:0]    pal_bank;
    logic [n_layers-1:0]         layer_on;
    logic [7:0]                  prog_addr;
    logic [3:0]                  prog_din;
    logic [2*n_layers-1:0]       prom_we;
    logic [n_layers-1:0][11:0]   map_addr;
    logic [n_layers-1:0]         map_cs;
    logic [n_layers-1:0][15:0]   map_data;
    logic [n_layers-1:0]         map_ok;
    logic [n_layers-1:0][13:2]   rom_addr;
    logic [n_layers-1:0][31:0]   rom_data;
    logic [n_layers-1:0]         rom_ok;
    logic [pxl_w-1:0]            pixel_out;
    logic [n_layers-1:0]         cs_seen;        // map_cs one clk back.
    logic [7:0]                  pal_copy [n_layers][256];
    logic [1:0]                  colour [n_layers];
    logic                        checking;       // screen filled, palettes valid.
    int                          cycles;
    int                          raster_clks;    // clks counted since reset release.

    scroll_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .pxl_cen   (pxl_cen),
        .h         (h),
        .v         (v),
        .hf        (hf),
        .hblank    (hblank),
        .vblank    (vblank),
        .hpos      (hpos),
        .pal_bank  (pal_bank),
        .layer_on  (layer_on),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .prom_we   (prom_we),
        .map_addr  (map_addr),
        .map_cs    (map_cs),
        .map_data  (map_data),
        .map_ok    (map_ok),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pixel_out (pixel_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // palette bits track the tile code taken from the address.
    function automatic logic [15:0] map_entry(input logic [11:0] addr);
        logic [5:0] code;
        code = addr[5:0] + addr[11:6];
        return {5'd0, code[2:0], 2'b00, code};
    endfunction

    function automatic logic [5:0] word_at(input int l, input logic [2:0] p);
        return pal_copy[l][{pal_bank[l], p, colour[l]}][5:0];
    endfunction

    // beam position implied by the clks since reset.
    function automatic int beam_col(input int clks);
        return (clks / 2) % int'(h_total);
    endfunction

    function automatic int beam_line(input int clks);
        return (clks / 2 / int'(h_total)) % int'(v_total);
    endfunction

    // every colour the mixer may show for the given layer enables
    function automatic bit pixel_allowed(input logic [5:0] pix, input logic [1:0] on);
        bit ok;
        bit see_back;
        ok = 1'b0;
        see_back = !on[0];
        for (int p = 0; p < 8; p++) begin
            if (on[0] && word_at(0, 3'(p)) == transparent_pxl) begin
                see_back = 1'b1;
            end else if (on[0] && word_at(0, 3'(p)) == pix) begin
                ok = 1'b1;
            end
        end
        if (see_back) begin
            if (!on[1] && pix == transparent_pxl) begin
                ok = 1'b1;
            end
            for (int q = 0; q < 8; q++) begin
                if (on[1] && word_at(1, 3'(q)) == pix) begin
                    ok = 1'b1;
                end
            end
        end
        return ok;
    endfunction

    function automatic logic [15:0] ahead_col(input logic [9:0] col,
            input logic [15:0] scroll, input int l, input logic flp);
        logic [15:0] ahead;
        ahead = scroll + layer_hoffset[l] + {{6{col[9]}}, col};
        return flp ? ahead - 16'd27 : ahead + 16'd16;  // alignment and one tile ahead.
    endfunction

    function automatic logic [11:0] map_addr_model(input logic [9:0] col,
            input logic [15:0] scroll, input int l, input logic flp, input logic [8:0] line);
        logic [15:0] ahead;
        ahead = ahead_col(col, scroll, l, flp);
        return {ahead[13:8], line[7:5] ^ {3{flp}}, ahead[7:5]};
    endfunction

    // the half bit is mirrored along with the flipped tile
    function automatic logic [13:2] rom_addr_model(input logic [9:0] col,
            input logic [15:0] scroll, input int l, input logic flp, input logic [8:0] line,
            input logic [15:0] entry);
        logic [15:0] ahead;
        ahead = ahead_col(col, scroll, l, flp);
        return {entry[5:0], line[4:0] ^ {5{flp}}, ahead[4] ^ flp};
    endfunction

    // map rom answers two clks after a request and holds its data.
    always @(posedge clk) begin
        for (int i = 0; i < n_layers; i++) begin
            if (map_cs[i] && cs_seen[i] && !map_ok[i]) begin
                map_data[i] <= #1 map_entry(map_addr[i]);
            end
            map_ok[i] <= #1 map_cs[i] && cs_seen[i];
            cs_seen[i] <= map_cs[i];
        end
    end

    // uniform tile rows with the msb plane in each low nibble.
    for (genvar i = 0; i < n_layers; i++) begin : g_tile_rom
        assign rom_data[i] = {4{{4{colour[i][0]}}, {4{colour[i][1]}}}};
        assign rom_ok[i]   = 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_clks) begin
            abort_run("timeout: the run did not finish within four frames");
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            raster_clks <= 0;
        end else begin
            raster_clks <= raster_clks + 1;
        end
    end

    raster_count: assert property (@(posedge clk) disable iff (rst)
        pxl_cen == raster_clks[0]
            && int'(h) == beam_col(raster_clks) && int'(v) == beam_line(raster_clks)
            && hblank == (beam_col(raster_clks) >= int'(h_active_end))
            && vblank == (beam_line(raster_clks) >= int'(v_active_end)))
        else abort_run($sformatf("error: %0t ns: raster pxl_cen %b h %0d v %0d blank %b%b",
                                 $time, pxl_cen, h, v, hblank, vblank));

    column_flip: assert property (@(posedge clk) disable iff (rst)
        hf[7:0] == ($past(h[7:0]) ^ {8{$past(flip)}}))
        else abort_run($sformatf("error: %0t ns: hf %h wrong", $time, hf));

    reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> (map_cs == '0 && pixel_out == '0))
        else abort_run($sformatf("error: %0t ns: map_cs %b pixel_out %h around reset",
                                 $time, map_cs, pixel_out));

    blank_black: assert property (@(posedge clk) disable iff (rst)
        $past(hblank || vblank) |-> pixel_out == '0)
        else abort_run($sformatf("error: %0t ns: pixel_out %h in blanking", $time, pixel_out));

    pixel_lookup: assert property (@(posedge clk) disable iff (rst)
        (checking && !$past(hblank || vblank)) |-> pixel_allowed(pixel_out, $past(layer_on)))
        else abort_run($sformatf("error: %0t ns: pixel_out %h not expected, layer_on %b",
                                 $time, pixel_out, layer_on));

    for (genvar i = 0; i < n_layers; i++) begin : g_map_check
        map_request: assert property (@(posedge clk) disable iff (rst)
            $rose(map_cs[i]) |-> map_addr[i] ==
                map_addr_model($past(hf), $past(hpos[i]), i, $past(flip), $past(v)))
            else abort_run($sformatf("error: %0t ns: layer %0d map_addr %h wrong",
                                     $time, i, map_addr[i]));

        rom_request: assert property (@(posedge clk) disable iff (rst)
            $fell(map_cs[i]) |-> rom_addr[i] ==
                rom_addr_model($past(hf), $past(hpos[i]), i, $past(flip), $past(v),
                               $past(map_data[i])))
            else abort_run($sformatf("error: %0t ns: layer %0d rom_addr %h wrong",
                                     $time, i, rom_addr[i]));
    end

    task automatic write_nibble(input int sel, input logic [7:0] addr, input logic [3:0] nib);
        @(posedge clk);
        #1;
        prog_addr    = addr;
        prog_din     = nib;
        prom_we      = '0;
        prom_we[sel] = 1'b1;
    endtask

    task automatic load_palettes();
        logic [7:0] w;
        for (int l = 0; l < n_layers; l++) begin
            for (int a = 0; a < 256; a++) begin
                w = 8'($urandom);
                if (l == 0 && (a >> 2) % 8 == 7) begin
                    w[5:0] = transparent_pxl;  // front palette 7 shows layer 1.
                end
                pal_copy[l][a] = w;
                write_nibble(2 * l, 8'(a), w[3:0]);
                write_nibble(2 * l + 1, 8'(a), w[7:4]);
            end
        end
        @(posedge clk);
        #1;
        prom_we = '0;
    endtask

    task automatic next_frame();
        @(posedge vblank);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_line(input logic [8:0] line);
        wait (v == line);
        @(posedge clk);
        #1;
    endtask

    task automatic set_scroll();
        for (int l = 0; l < n_layers; l++) begin
            hpos[l] = 16'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h65e90df3));
        rst         = 1'b1;
        flip        = 1'b0;
        hpos        = '0;
        layer_on    = '1;
        prog_addr   = '0;
        prog_din    = '0;
        prom_we     = '0;
        map_ok      = '0;
        cs_seen     = '0;
        checking    = 1'b0;
        cycles      = 0;
        raster_clks = 0;
        for (int l = 0; l < n_layers; l++) begin
            pal_bank[l] = 3'($urandom);
            colour[l]   = 2'($urandom);
            map_data[l] = map_entry(12'h000);
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        load_palettes();
        next_frame();
        set_scroll();  // scroll and flip only move in vblank.
        checking = 1'b1;
        wait_line(9'd112);
        layer_on = 2'b10;
        next_frame();
        flip     = 1'b1;
        layer_on = 2'b11;
        set_scroll();
        wait_line(9'd112);
        layer_on = 2'b00;
        next_frame();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/scroll_pkg.sv
hdl/pal_prom.sv
hdl/video_timing.sv
hdl/scroll_layer.sv
hdl/layer_mixer.sv
hdl/scroll_top.sv
tests/tb_scroll_top.sv

/* Bender.yml */
package:
  name: scroll_video

sources:
  - files:
      - hdl/scroll_pkg.sv
      - hdl/pal_prom.sv
      - hdl/video_timing.sv
      - hdl/scroll_layer.sv
      - hdl/layer_mixer.sv
      - hdl/scroll_top.sv

  - target: test
    files:
      - tests/tb_scroll_top.sv
